/* alu_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
    input  logic                            clk,
    input  logic                            rstn,
    issue_if.dst                            iss,
    output logic                            ex_valid,
    output logic [core_cfg_pkg::REG_AW-1:0] ex_rd,
    output logic [core_cfg_pkg::XLEN-1:0]   ex_result,
    wb_if.src                               wb
);

    logic [4:0]                    shamt;
    logic [core_cfg_pkg::XLEN-1:0] result;

    assign shamt = iss.opb[4:0];

    always_comb begin
        case (iss.op)
            rv_isa_pkg::ALU_ADD:  result = iss.opa + iss.opb;
            rv_isa_pkg::ALU_SUB:  result = iss.opa - iss.opb;
            rv_isa_pkg::ALU_SLL:  result = iss.opa << shamt;
            rv_isa_pkg::ALU_SLT: begin
                result = {{(core_cfg_pkg::XLEN-1){1'b0}},
                          ($signed(iss.opa) < $signed(iss.opb))};
            end
            rv_isa_pkg::ALU_SLTU: begin
                result = {{(core_cfg_pkg::XLEN-1){1'b0}}, (iss.opa < iss.opb)};
            end
            rv_isa_pkg::ALU_XOR:  result = iss.opa ^ iss.opb;
            rv_isa_pkg::ALU_SRL:  result = iss.opa >> shamt;
            // arithmetic shift keeps the sign bit.
            rv_isa_pkg::ALU_SRA:  result = $unsigned($signed(iss.opa) >>> shamt);
            rv_isa_pkg::ALU_OR:   result = iss.opa | iss.opb;
            rv_isa_pkg::ALU_AND:  result = iss.opa & iss.opb;
            default:              result = '0;
        endcase
    end

    // bypass to decode in the same cycle.
    assign ex_valid  = iss.valid;
    assign ex_rd     = iss.rd;
    assign ex_result = result;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= iss.valid;
        end
    end

    // ex/wb payload.
    always_ff @(posedge clk) begin
        wb.pc   <= iss.pc;
        wb.rd   <= iss.rd;
        wb.data <= result;
    end

endmodule

`default_nettype wire

/* core_cfg_pkg.sv */
`default_nettype none

package core_cfg_pkg;

    // data path width.
    localparam int XLEN = 32;

    // register index width.
    localparam int REG_AW = 5;

    // axi write response codes.
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_top #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            run,
    input  logic [core_cfg_pkg::XLEN-1:0]   awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [core_cfg_pkg::XLEN-1:0]   wdata,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    output logic                            halted,
    output logic                            retire_valid,
    output logic [core_cfg_pkg::XLEN-1:0]   retire_pc,
    output logic [core_cfg_pkg::REG_AW-1:0] retire_rd,
    output logic [core_cfg_pkg::XLEN-1:0]   retire_data
);

    logic                            imem_en;
    logic [$clog2(IMEM_DEPTH)-1:0]   imem_addr;
    logic [core_cfg_pkg::XLEN-1:0]   imem_rdata;
    logic                            if_valid;
    logic [core_cfg_pkg::XLEN-1:0]   if_pc;
    logic [core_cfg_pkg::REG_AW-1:0] rs1_addr;
    logic [core_cfg_pkg::REG_AW-1:0] rs2_addr;
    logic [core_cfg_pkg::XLEN-1:0]   rs1_data;
    logic [core_cfg_pkg::XLEN-1:0]   rs2_data;
    logic                            ex_valid;
    logic [core_cfg_pkg::REG_AW-1:0] ex_rd;
    logic [core_cfg_pkg::XLEN-1:0]   ex_result;

    issue_if iss_bus ();
    wb_if    wb_bus ();

    instr_mem #(.IMEM_DEPTH(IMEM_DEPTH)) u_instr_mem (
        .clk        (clk),
        .rstn       (rstn),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .imem_en    (imem_en),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata)
    );

    fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch_unit (
        .clk        (clk),
        .rstn       (rstn),
        .run        (run),
        .imem_rdata (imem_rdata),
        .imem_en    (imem_en),
        .imem_addr  (imem_addr),
        .if_valid   (if_valid),
        .if_pc      (if_pc),
        .halted     (halted)
    );

    decode_unit u_decode_unit (
        .clk       (clk),
        .rstn      (rstn),
        .if_valid  (if_valid),
        .if_pc     (if_pc),
        .instr     (imem_rdata),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .ex_valid  (ex_valid),
        .ex_rd     (ex_rd),
        .ex_result (ex_result),
        .wb        (wb_bus),
        .iss       (iss_bus)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rstn     (rstn),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb_bus)
    );

    alu_unit u_alu_unit (
        .clk       (clk),
        .rstn      (rstn),
        .iss       (iss_bus),
        .ex_valid  (ex_valid),
        .ex_rd     (ex_rd),
        .ex_result (ex_result),
        .wb        (wb_bus)
    );

    // retirement is the register file write.
    assign retire_valid = wb_bus.valid;
    assign retire_pc    = wb_bus.pc;
    assign retire_rd    = wb_bus.rd;
    assign retire_data  = wb_bus.data;

endmodule

`default_nettype wire

/* decode_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_unit (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            if_valid,
    input  logic [core_cfg_pkg::XLEN-1:0]   if_pc,
    input  logic [core_cfg_pkg::XLEN-1:0]   instr,
    output logic [core_cfg_pkg::REG_AW-1:0] rs1_addr,
    output logic [core_cfg_pkg::REG_AW-1:0] rs2_addr,
    input  logic [core_cfg_pkg::XLEN-1:0]   rs1_data,
    input  logic [core_cfg_pkg::XLEN-1:0]   rs2_data,
    input  logic                            ex_valid,
    input  logic [core_cfg_pkg::REG_AW-1:0] ex_rd,
    input  logic [core_cfg_pkg::XLEN-1:0]   ex_result,
    wb_if.sink                              wb,
    issue_if.src                            iss
);

    rv_isa_pkg::instr_t            iw;
    rv_isa_pkg::alu_op_e           op;
    logic                          is_op;
    logic                          is_imm;
    logic                          alt;
    logic                          issue;
    logic [core_cfg_pkg::XLEN-1:0] imm;
    logic [core_cfg_pkg::XLEN-1:0] src1;
    logic [core_cfg_pkg::XLEN-1:0] src2;

    // youngest producer wins.
    function automatic logic [core_cfg_pkg::XLEN-1:0] fwd(
        input logic [core_cfg_pkg::REG_AW-1:0] addr,
        input logic [core_cfg_pkg::XLEN-1:0]   rf_data
    );
        logic [core_cfg_pkg::XLEN-1:0] val;
        val = rf_data;
        if (wb.valid && (wb.rd == addr)) begin
            val = wb.data;
        end
        if (ex_valid && (ex_rd == addr)) begin
            val = ex_result;
        end
        if (addr == '0) begin
            val = '0;
        end
        return val;
    endfunction

    assign iw       = instr;
    assign rs1_addr = iw.r.rs1;
    assign rs2_addr = iw.r.rs2;
    assign is_op    = (iw.r.opcode == rv_isa_pkg::OPC_OP);
    assign is_imm   = (iw.i.opcode == rv_isa_pkg::OPC_OP_IMM);
    assign alt      = (iw.r.funct7 == rv_isa_pkg::F7_ALT);
    assign imm      = {{(core_cfg_pkg::XLEN-12){iw.i.imm12[11]}}, iw.i.imm12};

    assign src1  = fwd(rs1_addr, rs1_data);
    // immediate view replaces rs2 for op-imm.
    assign src2  = is_op ? fwd(rs2_addr, rs2_data) : imm;
    assign issue = if_valid && (is_op || is_imm) && (iw.r.rd != '0);

    always_comb begin
        op = rv_isa_pkg::ALU_ADD;
        case (iw.r.funct3)
            rv_isa_pkg::F3_ADD_SUB: begin
                // no subi in the isa.
                op = (is_op && alt) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            end
            rv_isa_pkg::F3_SLL:     op = rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     op = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    op = rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     op = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      op = rv_isa_pkg::ALU_OR;
            rv_isa_pkg::F3_AND:     op = rv_isa_pkg::ALU_AND;
            default:                op = rv_isa_pkg::ALU_ADD;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            iss.valid <= 1'b0;
        end else begin
            iss.valid <= issue;
        end
    end

    // id/ex payload.
    always_ff @(posedge clk) begin
        iss.pc  <= if_pc;
        iss.rd  <= iw.r.rd;
        iss.op  <= op;
        iss.opa <= src1;
        iss.opb <= src2;
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
    parameter int IMEM_DEPTH = 256,
    localparam int AW = $clog2(IMEM_DEPTH)
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          run,
    input  logic [core_cfg_pkg::XLEN-1:0] imem_rdata,
    output logic                          imem_en,
    output logic [AW-1:0]                 imem_addr,
    output logic                          if_valid,
    output logic [core_cfg_pkg::XLEN-1:0] if_pc,
    output logic                          halted
);

    localparam logic [core_cfg_pkg::XLEN-1:0] PC_STEP = 4;
    localparam logic [core_cfg_pkg::XLEN-1:0] END_PC  = IMEM_DEPTH * 4;

    logic [core_cfg_pkg::XLEN-1:0] pc;
    logic [core_cfg_pkg::XLEN-1:0] fetch_pc_q;
    logic                          fetch_v_q;
    logic                          stop_hit;
    logic                          pc_end;
    logic                          stopped;
    logic                          ex_busy;

    // zero word marks the end of the program.
    assign stop_hit  = fetch_v_q && (imem_rdata == '0);
    assign pc_end    = (pc == END_PC);
    assign imem_en   = run && !stopped && !stop_hit && !pc_end;
    assign imem_addr = pc[AW+1:2];
    assign if_valid  = fetch_v_q && !stop_hit;
    assign if_pc     = fetch_pc_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc        <= '0;
            fetch_v_q <= 1'b0;
            stopped   <= 1'b0;
            ex_busy   <= 1'b0;
            halted    <= 1'b0;
        end else begin
            fetch_v_q <= imem_en;
            if (imem_en) begin
                pc <= pc + PC_STEP;
            end
            if (stop_hit || (run && pc_end)) begin
                stopped <= 1'b1;
            end
            // shadow of the execute stage valid.
            ex_busy <= if_valid;
            // decode and execute empty, last writeback retires now.
            if (stopped && !if_valid && !ex_busy) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_en) begin
            fetch_pc_q <= pc;
        end
    end

    // nothing fetched and nothing left in flight once halted.
    no_fetch_halted: assert property (@(posedge clk) disable iff (!rstn)
        halted |-> !imem_en && !fetch_v_q && !ex_busy);

endmodule

`default_nettype wire

/* instr_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_mem #(
    parameter int IMEM_DEPTH = 256,
    localparam int AW = $clog2(IMEM_DEPTH)
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [core_cfg_pkg::XLEN-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [core_cfg_pkg::XLEN-1:0] wdata,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic                          imem_en,
    input  logic [AW-1:0]                 imem_addr,
    output logic [core_cfg_pkg::XLEN-1:0] imem_rdata
);

    localparam logic [core_cfg_pkg::XLEN-1:0] MEM_BYTES = IMEM_DEPTH * 4;

    logic [core_cfg_pkg::XLEN-1:0] mem [IMEM_DEPTH];
    logic                          in_range;
    logic                          wr_fire;
    logic                          accept;

    assign in_range = (awaddr < MEM_BYTES);
    assign wr_fire  = awready && awvalid && wvalid;
    // both channels present and no response outstanding.
    assign accept   = awvalid && wvalid && !bvalid && !awready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= accept;
            wready  <= accept;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= in_range ? core_cfg_pkg::RESP_OKAY : core_cfg_pkg::RESP_SLVERR;
            // out of range words are dropped.
            if (in_range) begin
                mem[awaddr[AW+1:2]] <= wdata;
            end
        end
        if (imem_en) begin
            imem_rdata <= mem[imem_addr];
        end
    end

    bresp_held: assert property (@(posedge clk) disable iff (!rstn)
        bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

/* pipe_if.sv */
`timescale 1ns/100ps
`default_nettype none

// decode to execute, one beat per instruction.
interface issue_if;
    logic                              valid;
    logic [core_cfg_pkg::XLEN-1:0]     pc;
    logic [core_cfg_pkg::REG_AW-1:0]   rd;
    rv_isa_pkg::alu_op_e               op;
    logic [core_cfg_pkg::XLEN-1:0]     opa;
    logic [core_cfg_pkg::XLEN-1:0]     opb;

    modport src (output valid, pc, rd, op, opa, opb);
    modport dst (input valid, pc, rd, op, opa, opb);
endinterface

// writeback of a finished result.
interface wb_if;
    logic                              valid;
    logic [core_cfg_pkg::XLEN-1:0]     pc;
    logic [core_cfg_pkg::REG_AW-1:0]   rd;
    logic [core_cfg_pkg::XLEN-1:0]     data;

    modport src (output valid, pc, rd, data);
    modport sink (input valid, pc, rd, data);
endinterface

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [core_cfg_pkg::REG_AW-1:0] rs1_addr,
    input  logic [core_cfg_pkg::REG_AW-1:0] rs2_addr,
    output logic [core_cfg_pkg::XLEN-1:0]   rs1_data,
    output logic [core_cfg_pkg::XLEN-1:0]   rs2_data,
    wb_if.sink                              wb
);

    // x0 has no storage.
    logic [core_cfg_pkg::XLEN-1:0] regs [1:31];

    function automatic logic [core_cfg_pkg::XLEN-1:0] read_port(
        input logic [core_cfg_pkg::REG_AW-1:0] addr
    );
        logic [core_cfg_pkg::XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (wb.valid && (wb.rd == addr)) begin
            val = wb.data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // decode filters rd zero before issue.
    no_x0_write: assert property (@(posedge clk) disable iff (!rstn)
        wb.valid |-> (wb.rd != '0));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, and look for the pass line.
verilator --binary --assert --top-module tb_cpu_top -f src.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "^Simulation passed$" && exit 0 || exit 1

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // opcodes still decoded by the core.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    // turns add into sub and srl into sra.
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // same word seen as register or immediate format.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_t;

endpackage

`default_nettype wire

/* src.f */
+incdir+.
core_cfg_pkg.sv
rv_isa_pkg.sv
pipe_if.sv
instr_mem.sv
fetch_unit.sv
reg_file.sv
decode_unit.sv
alu_unit.sv
cpu_top.sv
tb_cpu_top.sv

/* tb_rv_model.svh */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH
`default_nettype none

// architectural state of the reference model.
logic [31:0] model_regs [32];

// expected retirements, oldest first.
logic [31:0] exp_pc_q   [$];
logic [4:0]  exp_rd_q   [$];
logic [31:0] exp_data_q [$];

// integer semantics of the ten kept operations.
function automatic logic [31:0] alu_ref(
    input rv_isa_pkg::alu_op_e op,
    input logic [31:0]         a,
    input logic [31:0]         b
);
    logic [63:0] ext;
    logic [4:0]  sh;
    logic [31:0] res;
    sh  = b[4:0];
    // sign-filled upper half feeds the arithmetic shift.
    ext = {{32{a[31]}}, a} >> sh;
    case (op)
        rv_isa_pkg::ALU_ADD:  res = a + b;
        rv_isa_pkg::ALU_SUB:  res = a + ~b + 32'd1;
        rv_isa_pkg::ALU_SLL:  res = a << sh;
        rv_isa_pkg::ALU_SLT:  res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
        rv_isa_pkg::ALU_SLTU: res = {31'b0, a < b};
        rv_isa_pkg::ALU_XOR:  res = a ^ b;
        rv_isa_pkg::ALU_SRL:  res = a >> sh;
        rv_isa_pkg::ALU_SRA:  res = ext[31:0];
        rv_isa_pkg::ALU_OR:   res = a | b;
        rv_isa_pkg::ALU_AND:  res = a & b;
        default:              res = 32'd0;
    endcase
    return res;
endfunction

task automatic model_reset();
    for (int r = 0; r < 32; r++) begin
        model_regs[r] = 32'd0;
    end
    exp_pc_q.delete();
    exp_rd_q.delete();
    exp_data_q.delete();
endtask

// executes one instruction, x0 writes are discarded.
task automatic model_step(
    input logic [31:0]         pc,
    input rv_isa_pkg::alu_op_e op,
    input bit                  use_imm,
    input logic [4:0]          rd,
    input logic [4:0]          rs1,
    input logic [4:0]          rs2,
    input logic [11:0]         imm
);
    logic [31:0] b;
    logic [31:0] res;
    b   = use_imm ? {{20{imm[11]}}, imm} : model_regs[rs2];
    res = alu_ref(op, model_regs[rs1], b);
    if (rd != 5'd0) begin
        model_regs[rd] = res;
        exp_pc_q.push_back(pc);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
    end
endtask

`default_nettype wire
`endif

/* tb_cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_top;

    localparam int IMEM_DEPTH = 256;
    localparam int AXI_TMO    = 20;
    localparam int RUN_TMO    = 400;
    localparam int RAND_PROGS = 5;
    localparam int RAND_LEN   = 40;

    logic        clk;
    logic        rstn;
    logic        run;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic        halted;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] prog [$];

    `include "tb_rv_model.svh"

    cpu_top #(.IMEM_DEPTH(IMEM_DEPTH)) u_cpu_top (
        .clk          (clk),
        .rstn         (rstn),
        .run          (run),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .halted       (halted),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("ERR %0t %s expected %h got %h", $time, sig, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s FAIL, %0d errors", name, errors - err_before);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rstn    <= 1'b0;
        run     <= 1'b0;
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
    endtask

    // one full-word write, address and data offered together.
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(awready && wready) && n < AXI_TMO);
        assert (awready && wready) else begin
            $display("write to %h was never accepted by the slave", addr);
            errors++;
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!bvalid && n < AXI_TMO);
        assert (bvalid) else begin
            $display("write to %h got no response", addr);
            errors++;
        end
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    function automatic logic [31:0] encode(
        input rv_isa_pkg::alu_op_e op,
        input bit                  use_imm,
        input logic [4:0]          rd,
        input logic [4:0]          rs1,
        input logic [4:0]          rs2,
        input logic [11:0]         imm
    );
        rv_isa_pkg::instr_t w;
        logic [2:0]         f3;
        logic [6:0]         f7;
        f7 = rv_isa_pkg::F7_BASE;
        case (op)
            rv_isa_pkg::ALU_SUB: begin
                f3 = rv_isa_pkg::F3_ADD_SUB;
                f7 = rv_isa_pkg::F7_ALT;
            end
            rv_isa_pkg::ALU_SLL:  f3 = rv_isa_pkg::F3_SLL;
            rv_isa_pkg::ALU_SLT:  f3 = rv_isa_pkg::F3_SLT;
            rv_isa_pkg::ALU_SLTU: f3 = rv_isa_pkg::F3_SLTU;
            rv_isa_pkg::ALU_XOR:  f3 = rv_isa_pkg::F3_XOR;
            rv_isa_pkg::ALU_SRL:  f3 = rv_isa_pkg::F3_SRL_SRA;
            rv_isa_pkg::ALU_SRA: begin
                f3 = rv_isa_pkg::F3_SRL_SRA;
                f7 = rv_isa_pkg::F7_ALT;
            end
            rv_isa_pkg::ALU_OR:   f3 = rv_isa_pkg::F3_OR;
            rv_isa_pkg::ALU_AND:  f3 = rv_isa_pkg::F3_AND;
            default:              f3 = rv_isa_pkg::F3_ADD_SUB;
        endcase
        if (use_imm) begin
            // shift immediates carry funct7 in the upper bits.
            if (f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SRL_SRA) begin
                w.i.imm12 = {f7, imm[4:0]};
            end else begin
                w.i.imm12 = imm;
            end
            w.i.rs1    = rs1;
            w.i.funct3 = f3;
            w.i.rd     = rd;
            w.i.opcode = rv_isa_pkg::OPC_OP_IMM;
        end else begin
            w.r.funct7 = f7;
            w.r.rs2    = rs2;
            w.r.rs1    = rs1;
            w.r.funct3 = f3;
            w.r.rd     = rd;
            w.r.opcode = rv_isa_pkg::OPC_OP;
        end
        return w;
    endfunction

    task automatic emit(input rv_isa_pkg::alu_op_e op, input bit use_imm, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
        model_step(32'(prog.size() * 4), op, use_imm, rd, rs1, rs2, imm);
        prog.push_back(encode(op, use_imm, rd, rs1, rs2, imm));
    endtask

    task automatic build_directed_program();
        rv_isa_pkg::alu_op_e op;
        model_reset();
        prog.delete();
        emit(rv_isa_pkg::ALU_ADD, 1'b1, 5'd1, 5'd0, 5'd0, 12'hffb);
        emit(rv_isa_pkg::ALU_ADD, 1'b1, 5'd2, 5'd0, 5'd0, 12'h003);
        emit(rv_isa_pkg::ALU_ADD, 1'b1, 5'd3, 5'd0, 5'd0, 12'h7ff);
        // each op both ways round, negative against positive.
        for (int k = 0; k < 10; k++) begin
            op = rv_isa_pkg::alu_op_e'(4'(k));
            emit(op, 1'b0, 5'd4, 5'd1, 5'd2, 12'h000);
            emit(op, 1'b0, 5'd5, 5'd2, 5'd1, 12'h000);
            if (op != rv_isa_pkg::ALU_SUB) begin
                emit(op, 1'b1, 5'd6, 5'd1, 5'd0, 12'h003);
                emit(op, 1'b1, 5'd7, 5'd3, 5'd0, 12'hffe);
            end
        end
        // x0 targets must not disturb later reads of x0.
        emit(rv_isa_pkg::ALU_ADD, 1'b1, 5'd0, 5'd1, 5'd0, 12'h007);
        emit(rv_isa_pkg::ALU_OR, 1'b0, 5'd0, 5'd3, 5'd2, 12'h000);
        emit(rv_isa_pkg::ALU_ADD, 1'b0, 5'd5, 5'd0, 5'd2, 12'h000);
        emit(rv_isa_pkg::ALU_OR, 1'b0, 5'd6, 5'd0, 5'd0, 12'h000);
        prog.push_back(32'd0);
    endtask

    task automatic build_random_program(input int len);
        rv_isa_pkg::alu_op_e op;
        bit                  use_imm;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [11:0]         imm;
        model_reset();
        prog.delete();
        for (int k = 0; k < len; k++) begin
            op      = rv_isa_pkg::alu_op_e'(4'($urandom % 10));
            use_imm = 1'($urandom % 2);
            if (use_imm && op == rv_isa_pkg::ALU_SUB) begin
                op = rv_isa_pkg::ALU_ADD;
            end
            // x0..x7 only, so neighbours depend on each other.
            rd  = 5'($urandom % 8);
            rs1 = 5'($urandom % 8);
            rs2 = 5'($urandom % 8);
            imm = 12'($urandom);
            emit(op, use_imm, rd, rs1, rs2, imm);
        end
        prog.push_back(32'd0);
    endtask

    task automatic check_retire();
        assert (exp_pc_q.size() > 0) else begin
            $display("retirement of pc %h at %0t with nothing left in the model",
                     retire_pc, $time);
            errors++;
        end
        assert (retire_rd != 5'd0) else begin
            $display("retirement at %0t shows rd zero", $time);
            errors++;
        end
        if (exp_pc_q.size() > 0) begin
            check_value("retire_pc", exp_pc_q.pop_front(), retire_pc);
            check_value("retire_rd", 32'(exp_rd_q.pop_front()), 32'(retire_rd));
            check_value("retire_data", exp_data_q.pop_front(), retire_data);
        end
    endtask

    task automatic run_program(input string name);
        int         err_before;
        int         expected;
        int         retired;
        int         n;
        logic [1:0] resp;
        err_before = errors;
        expected   = exp_pc_q.size();
        retired    = 0;
        apply_reset();
        for (int i = 0; i < prog.size(); i++) begin
            axi_write(32'(i * 4), prog[i], resp);
            check_value("bresp", 32'(core_cfg_pkg::RESP_OKAY), 32'(resp));
        end
        @(posedge clk);
        run <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (retire_valid) begin
                assert (!halted) else begin
                    $display("retirement at %0t while halted is high", $time);
                    errors++;
                end
                retired++;
                check_retire();
            end
        end while (!halted && n < RUN_TMO);
        assert (halted) else begin
            $display("program %s did not halt within %0d cycles", name, RUN_TMO);
            errors++;
        end
        check_value("retire count", 32'(expected), 32'(retired));
        // the pipeline is empty once halted.
        repeat (4) begin
            @(negedge clk);
            check_value("retire_valid", 32'd0, 32'(retire_valid));
        end
        @(posedge clk);
        run <= 1'b0;
        report_test(name, err_before);
    endtask

    task automatic check_reset_state();
        int err_before;
        err_before = errors;
        apply_reset();
        repeat (3) @(negedge clk);
        check_value("retire_valid", 32'd0, 32'(retire_valid));
        check_value("halted", 32'd0, 32'(halted));
        check_value("awready", 32'd0, 32'(awready));
        check_value("wready", 32'd0, 32'(wready));
        check_value("bvalid", 32'd0, 32'(bvalid));
        report_test("reset_state", err_before);
    endtask

    task automatic check_axi_resp();
        int         err_before;
        logic [1:0] resp;
        err_before = errors;
        apply_reset();
        axi_write(32'h0000_0000, 32'h0000_0013, resp);
        check_value("bresp", 32'(core_cfg_pkg::RESP_OKAY), 32'(resp));
        axi_write(32'((IMEM_DEPTH - 1) * 4), 32'h0000_0013, resp);
        check_value("bresp", 32'(core_cfg_pkg::RESP_OKAY), 32'(resp));
        // first word past the end, then far out of range.
        axi_write(32'(IMEM_DEPTH * 4), 32'hdead_beef, resp);
        check_value("bresp", 32'(core_cfg_pkg::RESP_SLVERR), 32'(resp));
        axi_write(32'hffff_fff0, 32'hdead_beef, resp);
        check_value("bresp", 32'(core_cfg_pkg::RESP_SLVERR), 32'(resp));
        report_test("axi_resp", err_before);
    endtask

    initial begin
        rstn    <= 1'b0;
        run     <= 1'b0;
        awaddr  <= 32'd0;
        awvalid <= 1'b0;
        wdata   <= 32'd0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'hd20e));
        check_reset_state();
        check_axi_resp();
        build_directed_program();
        run_program("directed_alu");
        for (int p = 0; p < RAND_PROGS; p++) begin
            build_random_program(RAND_LEN);
            run_program($sformatf("random_%0d", p));
        end
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
